/* clint.f */
clint_pkg.sv
clint_decode.sv
clint_req_queue.sv
clint_regs.sv
clint_top.sv
clint_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run; the exit status follows the simulation
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    --top-module clint_tb -f clint.f -o clint_sim &&
  ./obj_dir/clint_sim ||
  exit 1

/* clint_tb.sv */
`timescale 1ns/1ps

module clint_tb
  import clint_pkg::*;
();

  localparam int reset_cycles  = 8;
  localparam int access_cycles = 6;  // Issue, handshake and three cycles of latency
  localparam int access_count  = 46;
  localparam int poll_limit    = 3 * tick_divide + 4;
  localparam int burst_cycles  = 48;
  localparam int cycle_budget  =
    reset_cycles + access_cycles * access_count + 3 * poll_limit + burst_cycles;
  localparam logic [31:0] lcg_seed = 32'd90;

  logic                  clock;
  logic                  reset;
  logic                  req_valid;
  logic                  req_ready;
  logic                  req_store;
  logic                  req_size;
  logic [addr_width-1:0] req_addr;
  logic [data_width-1:0] req_wdata;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [data_width-1:0] resp_rdata;
  logic                  resp_error;
  logic                  msip;
  logic                  mtip;
  logic [data_width-1:0] mtime;

  logic [31:0]           lcg_state   = lcg_seed;
  int unsigned           cycle_count = 0;
  logic [data_width-1:0] expect_q [$];  // Responses still owed in issue order

  clint_top DUT (.*);

  // ====================
  // Clock and helpers
  // ====================
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic clint_data_u to_word(input logic [data_width-1:0] value);
    clint_data_u result;
    result.dword = value;
    return result;
  endfunction

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input clint_data_u exp, input clint_data_u act);
    if (act.dword !== exp.dword) begin
      stop_with_error($sformatf("Error %s: expected %h, actual %h", name, exp.dword, act.dword));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_mtime_range(input string name, input logic [data_width-1:0] low,
                                   input logic [data_width-1:0] high,
                                   input logic [data_width-1:0] act);
    if ($isunknown(act) || act < low || act > high) begin
      stop_with_error($sformatf("Error %s: expected %h to %h, actual %h",
                                name, low, high, act));
    end
  endtask

  // ====================
  // Bus tasks
  // ====================
  task automatic drive_request(input logic store, input logic size,
                               input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] wdata);
    req_valid = 1'b1;
    req_store = store;
    req_size  = size;
    req_addr  = addr;
    req_wdata = wdata;
  endtask

  task automatic run_access(input logic store, input logic size,
                            input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] wdata,
                            output clint_data_u rdata, output logic error);
    @(negedge clock);
    drive_request(store, size, addr, wdata);
    resp_ready = 1'b1;
    while (!req_ready) @(negedge clock);
    @(negedge clock);  // Handshake took place on the rising edge
    req_valid = 1'b0;
    while (!resp_valid) @(negedge clock);
    rdata.dword = resp_rdata;
    error = resp_error;
  endtask

  task automatic do_write(input string name, input logic size, input logic [addr_width-1:0] addr,
                          input logic [data_width-1:0] wdata, input logic exp_error);
    clint_data_u rdata;
    logic        error;
    run_access(1'b1, size, addr, wdata, rdata, error);
    check_flag({name, " error"}, exp_error, error);
    check_data({name, " data"}, to_word('0), rdata);
  endtask

  task automatic do_read(input string name, input logic size, input logic [addr_width-1:0] addr,
                         output clint_data_u rdata, input logic exp_error);
    logic error;
    run_access(1'b0, size, addr, '0, rdata, error);
    check_flag({name, " error"}, exp_error, error);
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic test_reset_msip();
    clint_data_u rd;
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    check_flag("reset msip", 1'b0, msip);
    check_flag("reset mtip", 1'b0, mtip);
    check_mtime_range("reset mtime", '0, '0, mtime);
    reset = 1'b1;
    do_write("msip set", 1'b0, addr_msip, 64'h1, 1'b0);
    check_flag("msip set output", 1'b1, msip);
    do_read("msip set read", 1'b0, addr_msip, rd, 1'b0);
    check_data("msip set read", to_word(64'h1), rd);
    do_write("msip clear", 1'b0, addr_msip, 64'h0, 1'b0);
    check_flag("msip clear output", 1'b0, msip);
    do_read("msip clear read", 1'b0, addr_msip, rd, 1'b0);
    check_data("msip clear read", to_word(64'h0), rd);
  endtask

  task automatic test_mtimecmp();
    clint_data_u value;
    clint_data_u half;
    clint_data_u rd;
    int          i;
    int          h;
    for (i = 0; i < 3; i++) begin
      value.word[1] = lcg_next();
      value.word[0] = lcg_next();
      do_write("mtimecmp dword write", 1'b1, addr_mtimecmp, value.dword, 1'b0);
      do_read("mtimecmp dword read", 1'b1, addr_mtimecmp, rd, 1'b0);
      check_data("mtimecmp dword read", value, rd);
      value.word[1] = lcg_next();
      value.word[0] = lcg_next();
      // Upper half of 32-bit write data is ignored
      do_write("mtimecmp low write", 1'b0, addr_mtimecmp, {lcg_next(), value.word[0]}, 1'b0);
      do_write("mtimecmp high write", 1'b0, addr_mtimecmp + 16'd4,
               {lcg_next(), value.word[1]}, 1'b0);
      do_read("mtimecmp merged read", 1'b1, addr_mtimecmp, rd, 1'b0);
      check_data("mtimecmp merged read", value, rd);
      for (h = 0; h < 2; h++) begin
        half.dword   = '0;
        half.word[0] = value.word[h];
        do_read("mtimecmp half read", 1'b0, addr_mtimecmp + 16'(4 * h), rd, 1'b0);
        check_data("mtimecmp half read", half, rd);
      end
    end
  endtask

  task automatic test_mtime_count();
    clint_data_u value;
    clint_data_u first;
    clint_data_u second;
    int unsigned start;
    value.word[1] = lcg_next() & 32'h7fff_ffff;  // No wrap inside the bound
    value.word[0] = lcg_next();
    start = cycle_count;
    do_write("mtime write", 1'b1, addr_mtime, value.dword, 1'b0);
    do_read("mtime read", 1'b1, addr_mtime, first, 1'b0);
    check_mtime_range("mtime read", value.dword,
                      value.dword + (cycle_count - start) / tick_divide + 1, first.dword);
    check_mtime_range("mtime output", first.dword,
                      value.dword + (cycle_count - start) / tick_divide + 1, mtime);
    repeat (3 * tick_divide) @(negedge clock);
    do_read("mtime reread", 1'b1, addr_mtime, second, 1'b0);
    // The idle wait alone spans three ticks
    check_mtime_range("mtime reread", first.dword + 3,
                      value.dword + (cycle_count - start) / tick_divide + 1, second.dword);
  endtask

  task automatic test_timer_interrupt();
    logic [data_width-1:0] base;
    int                    waited;
    do_write("mtimecmp max", 1'b1, addr_mtimecmp, '1, 1'b0);
    @(negedge clock);  // mtip lags the compare by a cycle
    check_flag("mtip with mtimecmp max", 1'b0, mtip);
    base = {32'h0, lcg_next()};
    do_write("mtime base", 1'b1, addr_mtime, base, 1'b0);
    do_write("mtimecmp near", 1'b1, addr_mtimecmp, base + 3, 1'b0);
    waited = 0;
    while (!mtip && waited < poll_limit) begin
      @(negedge clock);
      waited++;
    end
    if (!mtip) begin
      stop_with_error($sformatf("mtip did not rise within %0d cycles", poll_limit));
    end
    repeat (2 * tick_divide) begin
      @(negedge clock);
      check_flag("mtip held", 1'b1, mtip);
    end
  endtask

  task automatic test_bad_access();
    clint_data_u cmp_before;
    clint_data_u mtime_before;
    clint_data_u rd;
    int unsigned start;
    do_read("snapshot mtimecmp", 1'b1, addr_mtimecmp, cmp_before, 1'b0);
    do_read("snapshot mtime", 1'b1, addr_mtime, mtime_before, 1'b0);
    start = cycle_count;
    do_read("unmapped read", 1'b0, 16'h2000, rd, 1'b1);
    check_data("unmapped read", to_word('0), rd);
    do_write("unmapped write", 1'b0, 16'h8000, '1, 1'b1);
    do_read("misaligned mtime read", 1'b1, addr_mtime + 16'd4, rd, 1'b1);
    check_data("misaligned mtime read", to_word('0), rd);
    do_write("misaligned mtime write", 1'b0, addr_mtime + 16'd2, '0, 1'b1);
    do_write("misaligned mtimecmp write", 1'b1, addr_mtimecmp + 16'd4, '0, 1'b1);
    do_write("dword msip write", 1'b1, addr_msip, 64'h1, 1'b1);
    check_flag("msip after bad writes", 1'b0, msip);
    do_read("msip after bad writes", 1'b0, addr_msip, rd, 1'b0);
    check_data("msip after bad writes", to_word('0), rd);
    do_read("mtimecmp after bad writes", 1'b1, addr_mtimecmp, rd, 1'b0);
    check_data("mtimecmp after bad writes", cmp_before, rd);
    do_read("mtime after bad writes", 1'b1, addr_mtime, rd, 1'b0);
    check_mtime_range("mtime after bad writes", mtime_before.dword,
                      mtime_before.dword + (cycle_count - start) / tick_divide + 1, rd.dword);
  endtask

  task automatic test_back_pressure();
    clint_data_u           model_cmp;
    clint_data_u           wdata;
    clint_data_u           expected;
    clint_data_u           act;
    logic [addr_width-1:0] addr;
    logic                  model_msip;
    logic                  store;
    logic                  size;
    logic                  half;
    logic                  full;
    logic                  pending;
    logic                  take_now;
    logic [31:0]           pick;
    int                    kind;
    int                    issued;
    model_cmp.word[1] = lcg_next();
    model_cmp.word[0] = lcg_next();
    model_msip = 1'b1;
    do_write("burst setup mtimecmp", 1'b1, addr_mtimecmp, model_cmp.dword, 1'b0);
    do_write("burst setup msip", 1'b0, addr_msip, 64'h1, 1'b0);
    @(negedge clock);  // Setup response leaves before the stall
    resp_ready = 1'b0;
    full = 1'b0;
    issued = 0;
    while (!full && issued < 16) begin
      pick = lcg_next();
      wdata.word[1] = lcg_next();
      wdata.word[0] = lcg_next();
      kind  = pick % 6;  // 0..1 msip, 2..3 dword mtimecmp, 4..5 half mtimecmp
      half  = pick[8];
      store = (kind % 2) == 0;
      size  = kind == 2 || kind == 3;
      addr  = (kind < 2) ? addr_msip : addr_mtimecmp + ((kind >= 4 && half) ? 16'd4 : 16'd0);
      expected.dword = '0;
      if (kind < 2) begin
        if (store) model_msip = wdata.dword[0];
        else expected.dword[0] = model_msip;
      end else if (size) begin
        if (store) model_cmp = wdata;
        else expected = model_cmp;
      end else begin
        if (store) model_cmp.word[half] = wdata.word[0];
        else expected.word[0] = model_cmp.word[half];
      end
      drive_request(store, size, addr, wdata.dword);
      expect_q.push_back(expected.dword);
      issued++;
      if (req_ready) begin
        @(negedge clock);
      end else begin
        full = 1'b1;
      end
    end
    if (!full) begin
      stop_with_error("req_ready stayed high while responses were held");
    end
    resp_ready = 1'b1;
    pending = 1'b1;  // Last request still waits for req_ready
    while (pending || expect_q.size() != 0) begin
      if (resp_valid && expect_q.size() == 0) begin
        stop_with_error("Response arrived with no request outstanding");
      end else if (resp_valid) begin
        expected.dword = expect_q.pop_front();
        act.dword = resp_rdata;
        check_data("burst response", expected, act);
        check_flag("burst response error", 1'b0, resp_error);
      end
      take_now = pending && req_ready;
      @(negedge clock);
      if (take_now) begin
        req_valid = 1'b0;
        pending = 1'b0;
      end
    end
    repeat (4) begin
      @(negedge clock);
      if (resp_valid) stop_with_error("Extra response after the burst drained");
    end
  endtask

  // ====================
  // Sequence and watchdog
  // ====================
  initial begin
    reset      = 1'b0;
    req_valid  = 1'b0;
    req_store  = 1'b0;
    req_size   = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = 1'b1;
    test_reset_msip();
    test_mtimecmp();
    test_mtime_count();
    test_timer_interrupt();
    test_bad_access();
    test_back_pressure();
    $display("No errors");
    $finish;
  end

  initial begin
    repeat (2 * cycle_budget) @(posedge clock);
    stop_with_error("Timeout, the tests did not finish within the cycle budget");
  end

endmodule

/* clint_top.sv */
`timescale 1ns/1ps

module clint_top
  import clint_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  logic                  req_store,
  input  logic                  req_size,
  input  logic [addr_width-1:0] req_addr,
  input  logic [data_width-1:0] req_wdata,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output logic [data_width-1:0] resp_rdata,
  output logic                  resp_error,
  output logic                  msip,
  output logic                  mtip,
  output logic [data_width-1:0] mtime
);

  // Decoder to queue
  logic                  dec_valid;
  logic                  dec_ready;
  logic                  dec_store;
  logic [sel_width-1:0]  dec_sel;
  logic                  dec_half;
  logic                  dec_size;
  logic [data_width-1:0] dec_wdata;

  // Queue to registers
  logic                  q_valid;
  logic                  q_ready;
  logic                  q_store;
  logic [sel_width-1:0]  q_sel;
  logic                  q_half;
  logic                  q_size;
  logic [data_width-1:0] q_wdata;

  clint_decode u_decode (
    .clock, .reset,
    .req_valid, .req_ready, .req_store, .req_size, .req_addr, .req_wdata,
    .dec_valid, .dec_ready, .dec_store, .dec_sel, .dec_half, .dec_size, .dec_wdata
  );

  clint_req_queue u_queue (
    .clock, .reset,
    .in_valid (dec_valid), .in_ready (dec_ready), .in_store (dec_store),
    .in_sel   (dec_sel),   .in_half  (dec_half),  .in_size  (dec_size),
    .in_wdata (dec_wdata),
    .out_valid (q_valid), .out_ready (q_ready), .out_store (q_store),
    .out_sel   (q_sel),   .out_half  (q_half),  .out_size  (q_size),
    .out_wdata (q_wdata)
  );

  clint_regs u_regs (
    .clock, .reset,
    .q_valid, .q_ready, .q_store, .q_sel, .q_half, .q_size, .q_wdata,
    .resp_valid, .resp_ready, .resp_rdata, .resp_error,
    .msip, .mtip, .mtime
  );

endmodule

/* clint_regs.sv */
`timescale 1ns/1ps

module clint_regs
  import clint_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  q_valid,
  output logic                  q_ready,
  input  logic                  q_store,
  input  logic [sel_width-1:0]  q_sel,
  input  logic                  q_half,
  input  logic                  q_size,
  input  logic [data_width-1:0] q_wdata,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output logic [data_width-1:0] resp_rdata,
  output logic                  resp_error,
  output logic                  msip,
  output logic                  mtip,
  output logic [data_width-1:0] mtime
);

  logic [data_width-1:0] mtimecmp;
  logic [tick_width-1:0] prescale;
  logic                  tick;
  logic                  take;
  logic                  wr_en;

  clint_data_u cur_word;  // Register addressed by the queue head
  clint_data_u wr_word;
  clint_data_u merged;
  clint_data_u rd_word;

  // Next entry accepted as the held response leaves
  assign q_ready = !resp_valid || resp_ready;
  assign take    = q_valid && q_ready;
  assign wr_en   = take && q_store;
  assign tick    = prescale == tick_last;

  // ====================
  // Read and merge
  // ====================
  always_comb begin
    case (q_sel)
      sel_msip:     cur_word.dword = {{(data_width-1){1'b0}}, msip};
      sel_mtimecmp: cur_word.dword = mtimecmp;
      sel_mtime:    cur_word.dword = mtime;
      default:      cur_word.dword = '0;
    endcase

    wr_word.dword = q_wdata;

    // 32-bit write data arrives in the low half
    merged = cur_word;
    if (q_size) begin
      merged = wr_word;
    end else begin
      merged.word[q_half] = wr_word.word[0];
    end

    rd_word.dword = '0;
    if (q_size) begin
      rd_word = cur_word;
    end else begin
      rd_word.word[0] = cur_word.word[q_half];
    end
  end

  // ====================
  // Time base
  // ====================
  always_ff @(posedge clock) begin
    if (!reset) begin
      prescale <= '0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      msip     <= 1'b0;
      mtip     <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '0;
    end else begin
      mtip <= mtime >= mtimecmp;
      if (wr_en && q_sel == sel_mtime) begin
        mtime <= merged.dword;  // Software write wins over the tick
      end else if (tick) begin
        mtime <= mtime + 1'b1;
      end
      if (wr_en && q_sel == sel_mtimecmp) mtimecmp <= merged.dword;
      if (wr_en && q_sel == sel_msip) msip <= merged.dword[0];
    end
  end

  // ====================
  // Response register
  // ====================
  always_ff @(posedge clock) begin
    if (!reset) begin
      resp_valid <= 1'b0;
    end else if (take) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      resp_error <= q_sel == sel_none;
      // Stores and rejected accesses return zero
      resp_rdata <= (q_store || q_sel == sel_none) ? '0 : rd_word.dword;
    end
  end

  property p_resp_hold;
    @(posedge clock) disable iff (!reset)
      resp_valid && !resp_ready |=>
        resp_valid && $stable(resp_rdata) && $stable(resp_error);
  endproperty

  assert property (p_resp_hold)
    else $error("response changed before it was taken");

endmodule

/* clint_req_queue.sv */
`timescale 1ns/1ps

module clint_req_queue
  import clint_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic                  in_store,
  input  logic [sel_width-1:0]  in_sel,
  input  logic                  in_half,
  input  logic                  in_size,
  input  logic [data_width-1:0] in_wdata,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  out_store,
  output logic [sel_width-1:0]  out_sel,
  output logic                  out_half,
  output logic                  out_size,
  output logic [data_width-1:0] out_wdata
);

  logic                  store_mem [queue_depth];
  logic [sel_width-1:0]  sel_mem   [queue_depth];
  logic                  half_mem  [queue_depth];
  logic                  size_mem  [queue_depth];
  logic [data_width-1:0] wdata_mem [queue_depth];

  logic [queue_ptr_width-1:0]   wr_ptr;
  logic [queue_ptr_width-1:0]   rd_ptr;
  logic [queue_count_width-1:0] count;
  logic                         push;
  logic                         pop;

  assign in_ready  = count != queue_full;
  assign out_valid = count != '0;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Head entry is presented straight from storage
  assign out_store = store_mem[rd_ptr];
  assign out_sel   = sel_mem[rd_ptr];
  assign out_half  = half_mem[rd_ptr];
  assign out_size  = size_mem[rd_ptr];
  assign out_wdata = wdata_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (push) begin
      store_mem[wr_ptr] <= in_store;
      sel_mem[wr_ptr]   <= in_sel;
      half_mem[wr_ptr]  <= in_half;
      size_mem[wr_ptr]  <= in_size;
      wdata_mem[wr_ptr] <= in_wdata;
    end
  end

  // ====================
  // Pointers and count
  // ====================
  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  // Overflow or underflow of the count leaves the legal range
  assert property (@(posedge clock) disable iff (!reset)
    count <= queue_full)
    else $error("request queue count beyond its depth");

  assert property (@(posedge clock) disable iff (!reset)
    wr_ptr - rd_ptr == queue_ptr_width'(count))
    else $error("request queue pointers disagree with the count");

endmodule

/* clint_decode.sv */
`timescale 1ns/1ps

module clint_decode
  import clint_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  logic                  req_store,
  input  logic                  req_size,
  input  logic [addr_width-1:0] req_addr,
  input  logic [data_width-1:0] req_wdata,
  output logic                  dec_valid,
  input  logic                  dec_ready,
  output logic                  dec_store,
  output logic [sel_width-1:0]  dec_sel,
  output logic                  dec_half,
  output logic                  dec_size,
  output logic [data_width-1:0] dec_wdata
);

  logic                 load;
  logic                 aligned;
  logic                 hit_msip;
  logic                 hit_mtimecmp;
  logic                 hit_mtime;
  logic [sel_width-1:0] sel_next;

  // Output register refills when empty or being drained
  assign req_ready = !dec_valid || dec_ready;
  assign load      = req_valid && req_ready;

  // ====================
  // Address decode
  // ====================
  always_comb begin
    aligned = req_size ? (req_addr[2:0] == 3'b000) : (req_addr[1:0] == 2'b00);

    hit_msip     = req_addr[addr_width-1:2] == addr_msip[addr_width-1:2];
    hit_mtimecmp = req_addr[addr_width-1:3] == addr_mtimecmp[addr_width-1:3];
    hit_mtime    = req_addr[addr_width-1:3] == addr_mtime[addr_width-1:3];

    sel_next = sel_none;
    if (aligned) begin
      if (hit_msip && !req_size) begin  // msip is a 32-bit register
        sel_next = sel_msip;
      end else if (hit_mtimecmp) begin
        sel_next = sel_mtimecmp;
      end else if (hit_mtime) begin
        sel_next = sel_mtime;
      end
    end
  end

  // ====================
  // Output register
  // ====================
  always_ff @(posedge clock) begin
    if (!reset) begin
      dec_valid <= 1'b0;
    end else if (req_ready) begin
      dec_valid <= req_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      dec_store <= req_store;
      dec_sel   <= sel_next;
      dec_half  <= req_size ? 1'b0 : req_addr[2];  // Upper word of a 64-bit register
      dec_size  <= req_size;
      dec_wdata <= req_wdata;
    end
  end

  // Stalled output keeps its request intact
  property p_dec_hold;
    @(posedge clock) disable iff (!reset)
      dec_valid && !dec_ready |=>
        dec_valid && $stable({dec_store, dec_sel, dec_half, dec_size, dec_wdata});
  endproperty

  assert property (p_dec_hold)
    else $error("decoded request changed while stalled");

endmodule

/* clint_pkg.sv */
package clint_pkg;

  // ====================
  // Bus widths
  // ====================
  localparam int addr_width = 16;
  localparam int data_width = 64;
  localparam int half_width = data_width / 2;

  // ====================
  // Register map
  // ====================
  localparam logic [addr_width-1:0] addr_msip     = 16'h0000;
  localparam logic [addr_width-1:0] addr_mtimecmp = 16'h4000;
  localparam logic [addr_width-1:0] addr_mtime    = 16'hBFF8;

  // Register selects carried past the decoder
  localparam int sel_width = 2;

  localparam logic [sel_width-1:0] sel_msip     = 2'd0;
  localparam logic [sel_width-1:0] sel_mtimecmp = 2'd1;
  localparam logic [sel_width-1:0] sel_mtime    = 2'd2;
  localparam logic [sel_width-1:0] sel_none     = 2'd3;  // Unmapped or misaligned

  // ====================
  // Time base prescaler
  // ====================
  localparam int tick_divide = 4;  // Clock cycles per mtime increment
  localparam int tick_width  = $clog2(tick_divide);

  localparam logic [tick_width-1:0] tick_last = tick_width'(tick_divide - 1);

  // ====================
  // Request queue
  // ====================
  localparam int queue_depth       = 4;  // Power of two so the pointers wrap
  localparam int queue_ptr_width   = $clog2(queue_depth);
  localparam int queue_count_width = $clog2(queue_depth + 1);

  localparam logic [queue_count_width-1:0] queue_full =
    queue_count_width'(queue_depth);

  // Data word seen whole or as two 32-bit halves
  typedef union packed {
    logic [data_width-1:0]      dword;
    logic [1:0][half_width-1:0] word;  // word[0] is the low half
  } clint_data_u;

endpackage
